// ==== Makefile ====
# Verilator build and run of the weight-programming front end testbench

VERILATOR ?= verilator
TOP       ?= tb_ising_cfg
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal --x-assign unique --x-initial unique
RUNFLAGS  ?= +verilator+seed+$(SEED) +verilator+rand+reset+2

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
verilog/ising_pkg.sv
verilog/step_counter.sv
verilog/weight_mem.sv
verilog/mem_arbiter.sv
verilog/analog_cfg.sv
verilog/ising_cfg_top.sv
tb/tb_clk_gen.sv
tb/tb_ising_cfg.sv

// ==== tb/tb_clk_gen.sv ====
////////////////////////////////////////////////////////////
// Free-running testbench clock, 10 ns period, starts low.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

endmodule

// ==== tb/tb_ising_cfg.sv ====
////////////////////////////////////////////////////////////
// Assertions sample on the falling edge; inputs move 1 ns after the rise.
// Expected lines come from a cycle model of the run and a shadow copy
// of host rows. Runs use full length, trans_num = HADDR+1.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ising_cfg
    import ising_pkg::*;
();

    logic                clk;
    logic                rst;
    logic                en;
    logic                cfg_load;
    cfg_timing_t         timing;
    logic                start;
    host_wr_t            host_wr;
    logic                wr_drop;
    logic [NUM_SPIN-1:0] j_wwl;
    logic                h_wwl;
    logic [WBL_W-1:0]    wbl;
    logic                idle;

    // Shadow rows, and the copy frozen when a run starts
    logic [ROW_W-1:0]    shadow   [HADDR+1];
    logic [ROW_W-1:0]    run_rows [HADDR+1];
    int                  hi_len;
    int                  lo_len;
    logic                byp_mode;
    logic                run_on;
    int                  rel;
    int                  run_len;
    int                  per;
    int                  line_no;
    logic                line_hi;
    logic [NUM_SPIN-1:0] exp_j;
    logic                exp_h;
    logic [WBL_W-1:0]    raw_bus;
    logic [WBL_W-1:0]    exp_wbl;
    logic                drop_expect;
    int                  errors;
    int                  timeouts;
    string               test_name;

    tb_clk_gen i_clk_gen (.clk_o(clk));

    ising_cfg_top i_ising_cfg_top (
        .clk_i      (clk),
        .rst_i      (rst),
        .en_i       (en),
        .cfg_load_i (cfg_load),
        .timing_i   (timing),
        .start_i    (start),
        .host_wr_i  (host_wr),
        .wr_drop_o  (wr_drop),
        .j_wwl_o    (j_wwl),
        .h_wwl_o    (h_wwl),
        .wbl_o      (wbl),
        .idle_o     (idle)
    );

    // Macro code of one signed weight
    function automatic logic [BITDATA-1:0] macro_code(input logic signed [BITDATA-1:0] w);
        int v;
        v = w;
        if (v > 0) begin
            return BITDATA'(2 * v + 1);
        end else if (v == 0 || v == -(1 << (BITDATA - 1))) begin
            return '0;
        end
        return BITDATA'(-2 * v);
    endfunction

    function automatic logic [WBL_W-1:0] convert_bus(input logic [WBL_W-1:0] bus);
        logic [WBL_W-1:0] res;
        for (int i = 0; i < NUM_SPIN; i++) begin
            res[i*BITDATA +: BITDATA] = macro_code(bus[i*BITDATA +: BITDATA]);
        end
        return res;
    endfunction

    function automatic logic [ROW_W-1:0] random_row();
        logic [ROW_W-1:0] row;
        for (int i = 0; i < ROW_W / 32; i++) begin
            row[i*32 +: 32] = $urandom();
        end
        return row;
    endfunction

    // Run schedule: read and data cycles, then high and low per line
    always @(posedge clk) begin
        if (rst) begin
            run_on <= 1'b0;
            rel    <= 0;
        end else if (!en) begin
            run_on <= 1'b0;
        end else if (run_on) begin
            if (rel == run_len - 1) begin
                run_on <= 1'b0;
            end
            rel <= rel + 1;
        end else if (start) begin
            run_on <= 1'b1;
            rel    <= 0;
        end
    end

    always_comb begin
        per     = hi_len + lo_len;
        run_len = 2 + (NUM_SPIN + 1) * per;
        line_no = 0;
        line_hi = 1'b0;
        if (run_on && rel >= 2) begin
            line_no = (rel - 2) / per;
            line_hi = ((rel - 2) % per) < hi_len;
        end
        exp_j = '0;
        if (line_hi && line_no < NUM_SPIN) begin
            exp_j[line_no] = 1'b1;
        end
        exp_h = line_hi && (line_no == NUM_SPIN);
        if (line_no < NUM_SPIN) begin
            raw_bus = run_rows[line_no / PARALLELISM][(line_no % PARALLELISM)*WBL_W +: WBL_W];
        end else begin
            raw_bus = run_rows[HADDR][WBL_W-1:0];
        end
        exp_wbl = byp_mode ? raw_bus : convert_bus(raw_bus);
    end

    task automatic report_mismatch(input string check, input logic [WBL_W-1:0] expected,
                                   input logic [WBL_W-1:0] actual);
        errors++;
        $display("Fail %s: %s expected %h, actual %h", test_name, check, expected, actual);
    endtask

    a_word_lines: assert property (
        @(negedge clk) disable iff (rst)
        (j_wwl == exp_j) && (h_wwl == exp_h)
    ) else report_mismatch("word lines", WBL_W'({exp_h, exp_j}), WBL_W'({h_wwl, j_wwl}));

    a_idle: assert property (
        @(negedge clk) disable iff (rst)
        idle == !run_on
    ) else report_mismatch("idle", WBL_W'(!run_on), WBL_W'(idle));

    a_bit_lines: assert property (
        @(negedge clk) disable iff (rst)
        !line_hi || (wbl == exp_wbl)
    ) else report_mismatch("bit lines", exp_wbl, wbl);

    a_bit_lines_quiet: assert property (
        @(negedge clk) disable iff (rst)
        run_on || (wbl == '0)
    ) else report_mismatch("idle bit lines", '0, wbl);

    a_drop: assert property (
        @(negedge clk) disable iff (rst)
        wr_drop == drop_expect
    ) else report_mismatch("write drop", WBL_W'(drop_expect), WBL_W'(wr_drop));

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_row(input logic [ADDR_W-1:0] addr, input logic [ROW_W-1:0] data,
                             input logic dropped);
        host_wr.valid = 1'b1;
        host_wr.addr  = addr;
        host_wr.data  = data;
        drop_expect   = dropped;
        if (!dropped) begin
            shadow[addr] = data;
        end
    endtask

    task automatic end_write();
        host_wr     = '0;
        drop_expect = 1'b0;
    endtask

    task automatic load_timing(input int high, input int low, input logic byp);
        timing.wwl_high  = CNT_W'(high);
        timing.wwl_low   = CNT_W'(low);
        timing.trans_num = CNT_W'(HADDR + 1);
        timing.bypass    = byp;
        cfg_load         = 1'b1;
        hi_len           = high;
        lo_len           = low;
        byp_mode         = byp;
        next_cycle();
        cfg_load = 1'b0;
    endtask

    // Leaves the caller in the cycle of the first memory read
    task automatic start_run();
        for (int r = 0; r <= HADDR; r++) begin
            run_rows[r] = shadow[r];
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_for_quiet(input string what, input int limit);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = idle && (j_wwl == '0) && !h_wwl;
        end
        if (!seen) begin
            timeouts++;
            $display("Timeout: %s did not reach idle with word lines low in %0d cycles",
                     what, limit);
        end
        next_cycle();
    endtask

    initial begin
        int r;
        void'($urandom(32'h5475));
        errors      = 0;
        timeouts    = 0;
        test_name   = "reset";
        rst         = 1'b1;
        en          = 1'b0;
        cfg_load    = 1'b0;
        timing      = '0;
        start       = 1'b0;
        host_wr     = '0;
        drop_expect = 1'b0;
        hi_len      = 1;
        lo_len      = 1;
        byp_mode    = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        en  = 1'b1;
        repeat (5) next_cycle();

        test_name = "converted run";
        for (r = 0; r <= HADDR; r++) begin
            write_row(ADDR_W'(r), random_row(), 1'b0);
            next_cycle();
        end
        end_write();
        load_timing(3, 2, 1'b0);
        start_run();
        wait_for_quiet(test_name, 200);

        test_name = "bypass run";
        load_timing(3, 2, 1'b1);
        start_run();
        wait_for_quiet(test_name, 200);

        // First write parks behind the row 0 read, the second is lost
        test_name = "write during run";
        load_timing(3, 2, 1'b0);
        start_run();
        write_row(ADDR_W'(0), random_row(), 1'b0);
        next_cycle();
        write_row(ADDR_W'(1), random_row(), 1'b1);
        next_cycle();
        end_write();
        wait_for_quiet(test_name, 200);

        test_name = "write after run";
        start_run();
        wait_for_quiet(test_name, 200);

        test_name = "enable drop";
        start_run();
        repeat (30) next_cycle();
        en = 1'b0;
        wait_for_quiet(test_name, 10);
        en = 1'b1;
        next_cycle();

        test_name = "run after enable drop";
        start_run();
        wait_for_quiet(test_name, 200);

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/analog_cfg.sv ====
////////////////////////////////////////////////////////////
// Programs J lines 0..15 then the H line, one word line at a time.
// trans_num is the number of rows per run, HADDR+1 for a full run.
// Relies on rdata_i holding between reads; bypass is taken on cfg_load_i.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module analog_cfg
    import ising_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                en_i,
    input  logic                cfg_load_i,
    input  cfg_timing_t         timing_i,
    input  logic                start_i,
    output logic                j_ren_o,
    output logic [ADDR_W-1:0]   j_raddr_o,
    output logic                h_ren_o,
    input  logic [ROW_W-1:0]    rdata_i,
    output logic [NUM_SPIN-1:0] j_wwl_o,
    output logic                h_wwl_o,
    output logic [WBL_W-1:0]    wbl_o,
    output logic                idle_o
);

    cfg_state_e        state_q;
    cfg_state_e        state_d;
    logic              fetch_wait_q;
    logic              bypass_q;
    logic [SEL_W-1:0]  sel_q;
    logic [CNT_W-1:0]  row_q;
    logic [ADDR_W-1:0] nxt_row;
    logic [LINE_W-1:0] line_idx;
    logic              start_acc;
    logic              high_max;
    logic              low_max;
    logic              row_ovf;
    logic              is_h;
    logic              line_end;
    logic              row_end;
    logic              run_end;
    logic              next_rd;
    logic [WBL_W-1:0]  wbl_raw;
    logic [WBL_W-1:0]  wbl_conv;

    // Two's complement to the macro code: +v -> 2v+1, -v -> 2|v|, -8 -> 0
    function automatic logic [BITDATA-1:0] to_analog(input logic [BITDATA-1:0] v);
        logic [BITDATA-1:0] mag;
        mag = -v;
        if (v == '0 || v == {1'b1, {(BITDATA-1){1'b0}}}) begin
            to_analog = '0;
        end else if (!v[BITDATA-1]) begin
            to_analog = {v[BITDATA-2:0], 1'b1};
        end else begin
            to_analog = {mag[BITDATA-2:0], 1'b0};
        end
    endfunction

    assign idle_o    = (state_q == CFG_IDLE) || (state_q == CFG_DONE);
    assign start_acc = en_i & start_i & idle_o;
    assign is_h      = (row_q == CNT_W'(HADDR));

    // Sequencing events, all in the last low cycle of a line
    assign line_end = en_i & (state_q == CFG_LOW) & low_max;
    assign row_end  = line_end & (is_h | (sel_q == SEL_W'(PARALLELISM - 1)));
    assign run_end  = row_ovf | (row_end & is_h);
    assign next_rd  = row_end & ~run_end;
    assign nxt_row  = row_q[ADDR_W-1:0] + 1'b1;

    // Memory reads
    assign j_ren_o   = (en_i & (state_q == CFG_FETCH) & ~fetch_wait_q) |
                       (next_rd & (nxt_row != ADDR_W'(HADDR)));
    assign h_ren_o   = next_rd & (nxt_row == ADDR_W'(HADDR));
    assign j_raddr_o = (state_q == CFG_LOW) ? nxt_row : row_q[ADDR_W-1:0];

    always_comb begin
        state_d = state_q;
        if (!en_i) begin
            state_d = CFG_IDLE;
        end else begin
            case (state_q)
                CFG_IDLE, CFG_DONE: state_d = start_i ? CFG_FETCH : CFG_IDLE;
                CFG_FETCH: begin
                    if (fetch_wait_q) begin
                        state_d = CFG_HIGH;
                    end
                end
                CFG_HIGH: begin
                    if (high_max) begin
                        state_d = CFG_LOW;
                    end
                end
                CFG_LOW: begin
                    if (low_max) begin
                        state_d = run_end ? CFG_DONE : CFG_HIGH;
                    end
                end
                default: state_d = CFG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= CFG_IDLE;
            fetch_wait_q <= 1'b0;
            bypass_q     <= 1'b0;
            sel_q        <= '0;
        end else begin
            state_q      <= state_d;
            fetch_wait_q <= en_i & (state_q == CFG_FETCH) & ~fetch_wait_q;
            if (cfg_load_i) begin
                bypass_q <= timing_i.bypass;
            end
            // Quarter select moves with the rising edge of the next line
            if (start_acc) begin
                sel_q <= '0;
            end else if (line_end && !is_h) begin
                sel_q <= sel_q + 1'b1;
            end
        end
    end

    // Word lines decoded from the registered state
    assign line_idx = {row_q[LINE_W-SEL_W-1:0], sel_q};
    assign j_wwl_o  = (state_q == CFG_HIGH && !is_h) ? (NUM_SPIN'(1) << line_idx) : '0;
    assign h_wwl_o  = (state_q == CFG_HIGH) && is_h;

    // Bit lines follow the held row, zero outside the line phases
    assign wbl_raw = rdata_i[sel_q*WBL_W +: WBL_W];

    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            wbl_conv[i*BITDATA +: BITDATA] = to_analog(wbl_raw[i*BITDATA +: BITDATA]);
        end
    end

    assign wbl_o = (state_q == CFG_HIGH || state_q == CFG_LOW) ?
                   (bypass_q ? wbl_raw : wbl_conv) : '0;

    step_counter i_wwl_high_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .d_i        (timing_i.wwl_high),
        .recount_i  (start_acc),
        .step_i     (state_q == CFG_HIGH),
        .q_o        (),
        .maxed_o    (high_max),
        .overflow_o ()
    );

    step_counter i_wwl_low_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .d_i        (timing_i.wwl_low),
        .recount_i  (start_acc),
        .step_i     (state_q == CFG_LOW),
        .q_o        (),
        .maxed_o    (low_max),
        .overflow_o ()
    );

    step_counter i_row_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .d_i        (timing_i.trans_num),
        .recount_i  (start_acc),
        .step_i     (row_end),
        .q_o        (row_q),
        .maxed_o    (),
        .overflow_o (row_ovf)
    );

    a_j_wwl_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $onehot0(j_wwl_o)
    );

    a_h_j_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(h_wwl_o && (|j_wwl_o))
    );

endmodule

// ==== verilog/ising_cfg_top.sv ====
////////////////////////////////////////////////////////////
// Host write port, weight memory and configuration engine.
// Host writes may be delayed one cycle or dropped during engine reads.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ising_cfg_top
    import ising_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                en_i,
    input  logic                cfg_load_i,
    input  cfg_timing_t         timing_i,
    input  logic                start_i,
    input  host_wr_t            host_wr_i,
    output logic                wr_drop_o,
    output logic [NUM_SPIN-1:0] j_wwl_o,
    output logic                h_wwl_o,
    output logic [WBL_W-1:0]    wbl_o,
    output logic                idle_o
);

    logic              j_ren;
    logic [ADDR_W-1:0] j_raddr;
    logic              h_ren;
    mem_req_t          mem_req;
    logic [ROW_W-1:0]  rdata;

    mem_arbiter i_mem_arbiter (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .host_wr_i (host_wr_i),
        .j_ren_i   (j_ren),
        .j_raddr_i (j_raddr),
        .h_ren_i   (h_ren),
        .req_o     (mem_req),
        .wr_drop_o (wr_drop_o)
    );

    weight_mem i_weight_mem (
        .clk_i   (clk_i),
        .req_i   (mem_req),
        .rdata_o (rdata)
    );

    analog_cfg i_analog_cfg (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .cfg_load_i (cfg_load_i),
        .timing_i   (timing_i),
        .start_i    (start_i),
        .j_ren_o    (j_ren),
        .j_raddr_o  (j_raddr),
        .h_ren_o    (h_ren),
        .rdata_i    (rdata),
        .j_wwl_o    (j_wwl_o),
        .h_wwl_o    (h_wwl_o),
        .wbl_o      (wbl_o),
        .idle_o     (idle_o)
    );

endmodule

// ==== verilog/ising_pkg.sv ====
////////////////////////////////////////////////////////////
// Sizes, buses and FSM states of the weight-programming front end.
// Fixed at 16 spins, 4-bit weights and 4 word lines per memory row.
// Rows 0 to HADDR-1 hold J couplings, row HADDR holds the H bias.
////////////////////////////////////////////////////////////

package ising_pkg;

    localparam int NUM_SPIN    = 16;
    localparam int BITDATA     = 4;
    localparam int PARALLELISM = 4;
    localparam int HADDR       = NUM_SPIN / PARALLELISM;
    localparam int ADDR_W      = 3;
    localparam int ROW_W       = NUM_SPIN * BITDATA * PARALLELISM;
    localparam int WBL_W       = NUM_SPIN * BITDATA;
    localparam int CNT_W       = 16;

    // Line index and slice select widths inside the engine
    localparam int LINE_W = $clog2(NUM_SPIN);
    localparam int SEL_W  = $clog2(PARALLELISM);

    // Phase lengths in cycles; trans_num is the row count of one run
    typedef struct packed {
        logic [CNT_W-1:0] wwl_high;
        logic [CNT_W-1:0] wwl_low;
        logic [CNT_W-1:0] trans_num;
        logic             bypass;
    } cfg_timing_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [ROW_W-1:0]  data;
    } host_wr_t;

    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [ROW_W-1:0]  wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        CFG_IDLE,
        CFG_FETCH,
        CFG_HIGH,
        CFG_LOW,
        CFG_DONE
    } cfg_state_e;

endpackage

// ==== verilog/mem_arbiter.sv ====
////////////////////////////////////////////////////////////
// Engine reads always own the port; a colliding host write is parked.
// Any host write seen while the slot is full is lost (wr_drop_o).
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_arbiter
    import ising_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  host_wr_t          host_wr_i,
    input  logic              j_ren_i,
    input  logic [ADDR_W-1:0] j_raddr_i,
    input  logic              h_ren_i,
    output mem_req_t          req_o,
    output logic              wr_drop_o
);

    host_wr_t pend_q;
    logic     rd;
    logic     park;
    logic     retire;

    assign rd     = j_ren_i | h_ren_i;
    assign park   = host_wr_i.valid & rd & ~pend_q.valid;
    assign retire = pend_q.valid & ~rd;

    assign wr_drop_o = host_wr_i.valid & pend_q.valid;

    always_comb begin
        req_o = '0;
        if (rd) begin
            req_o.ren  = 1'b1;
            req_o.addr = h_ren_i ? ADDR_W'(HADDR) : j_raddr_i;
        end else if (pend_q.valid && !rst_i) begin
            req_o.wen   = 1'b1;
            req_o.addr  = pend_q.addr;
            req_o.wdata = pend_q.data;
        end else if (host_wr_i.valid) begin
            req_o.wen   = 1'b1;
            req_o.addr  = host_wr_i.addr;
            req_o.wdata = host_wr_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (park) begin
            pend_q.addr <= host_wr_i.addr;
            pend_q.data <= host_wr_i.data;
        end
        if (rst_i) begin
            pend_q.valid <= 1'b0;
        end else if (park) begin
            pend_q.valid <= 1'b1;
        end else if (retire) begin
            pend_q.valid <= 1'b0;
        end
    end

    a_single_read: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(j_ren_i && h_ren_i)
    );

endmodule

// ==== verilog/step_counter.sv ====
////////////////////////////////////////////////////////////
// Counts 0 .. terminal-1 and wraps; a terminal of 0 acts as 1.
// Loading a new terminal also clears the running count.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module step_counter
    import ising_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             en_i,
    input  logic             load_i,
    input  logic [CNT_W-1:0] d_i,
    input  logic             recount_i,
    input  logic             step_i,
    output logic [CNT_W-1:0] q_o,
    output logic             maxed_o,
    output logic             overflow_o
);

    logic [CNT_W-1:0] term_q;
    logic [CNT_W-1:0] count_q;

    // Extra bit keeps the compare clean at the top of the range
    assign maxed_o    = ({1'b0, count_q} + 1'b1) >= {1'b0, term_q};
    assign overflow_o = en_i & step_i & ~recount_i & maxed_o;
    assign q_o        = count_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            term_q  <= '0;
            count_q <= '0;
        end else if (load_i) begin
            term_q  <= d_i;
            count_q <= '0;
        end else if (en_i) begin
            if (recount_i || overflow_o) begin
                count_q <= '0;
            end else if (step_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    a_count_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        count_q <= term_q
    );

endmodule

// ==== verilog/weight_mem.sv ====
////////////////////////////////////////////////////////////
// HADDR+1 rows of ROW_W bits, one read or write per cycle.
// rdata_o is registered and holds its value until the next read.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module weight_mem
    import ising_pkg::*;
(
    input  logic             clk_i,
    input  mem_req_t         req_i,
    output logic [ROW_W-1:0] rdata_o
);

    localparam int DEPTH = HADDR + 1;

    logic [ROW_W-1:0] mem_q [DEPTH];
    logic [ROW_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i.wen) begin
            mem_q[req_i.addr] <= req_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.ren) begin
            rdata_q <= mem_q[req_i.addr];
        end
    end

    assign rdata_o = rdata_q;

    // The arbiter grants one access per cycle to a populated row
    a_req_legal: assert property (
        @(posedge clk_i)
        (req_i.ren || req_i.wen) |->
            !(req_i.ren && req_i.wen) && (req_i.addr <= ADDR_W'(HADDR))
    );

endmodule
